//--- list.f
+incdir+src
src/core_types_pkg.sv
src/mem_req_pkg.sv
src/operand_collector.sv
src/store_addr_calc.sv
src/stamofu_addr_pipeline.sv
src/stamofu_addr_top.sv
sim/stamofu_addr_properties.sv
sim/stamofu_addr_tb.sv

//--- sim/stamofu_addr_properties.sv
`timescale 1ns/100ps

module stamofu_addr_properties (
	input logic CLK,
	input logic nRST,
	input logic issue_valid,
	input logic issue_ready,
	input logic oc_valid,
	input core_types_pkg::issue_op_t oc_op,
	input logic REQ_valid,
	input logic REQ_ack,
	input mem_req_pkg::mem_req_t REQ,
	input logic last_issue_ready,
	input logic last_REQ_valid,
	input mem_req_pkg::mem_req_t last_REQ
);

	// held request, seen inside and at the output register one cycle later
	assert property (@(posedge CLK) disable iff (!nRST)
		(REQ_valid && !REQ_ack) |=> (REQ_valid && $stable(REQ)))
		else $error("REQ changed or dropped before ack");

	assert property (@(posedge CLK) disable iff (!nRST)
		(REQ_valid && !REQ_ack) |-> ##2 (last_REQ_valid && $stable(last_REQ)))
		else $error("last_REQ changed or dropped before ack");

	// outputs still cleared on reset release and ready high one cycle later
	assert property (@(posedge CLK) $rose(nRST)
		|-> (!last_REQ_valid && !last_issue_ready) ##1 last_issue_ready)
		else $error("outputs not cleared by reset or issue ready did not rise");

	// a refused issue leaves the collector untouched
	assert property (@(posedge CLK) disable iff (!nRST)
		(issue_valid && !issue_ready) |=> (oc_valid && $stable(oc_op)))
		else $error("issue taken while not ready");

endmodule

bind stamofu_addr_top stamofu_addr_properties props (
	.CLK(CLK),
	.nRST(nRST),
	.issue_valid(issue_valid),
	.issue_ready(issue_ready),
	.oc_valid(pipeline.oc_valid),
	.oc_op(pipeline.oc_op),
	.REQ_valid(REQ_valid),
	.REQ_ack(REQ_ack),
	.REQ(REQ),
	.last_issue_ready(last_issue_ready),
	.last_REQ_valid(last_REQ_valid),
	.last_REQ(last_REQ)
);

//--- sim/stamofu_addr_tb.sv
`timescale 1ns/100ps

`include "stamofu_cfg.svh"

module stamofu_addr_tb;
	import core_types_pkg::*;
	import mem_req_pkg::*;

	logic CLK;
	logic nRST;
	logic next_issue_valid;
	issue_op_t next_issue;
	reg_resp_t next_A_reg_resp;
	reg_resp_t next_B_reg_resp;
	logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] next_bus_forward_data_by_bank;
	logic [`STAMOFU_FF_PIPE_COUNT-1:0] next_fast_forward_valid_by_pipe;
	logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] next_fast_forward_data_by_pipe;
	logic next_REQ_ack;
	logic last_issue_ready;
	logic last_REQ_valid;
	mem_req_t last_REQ;

	mem_req_t exp_q[$];
	string test_name = "reset";
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int ack_pct = 70;
	bit hung = 0;

	stamofu_addr_top DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// ----------------------------------------------------------
	// random ack and REQ checker

	// the ack driven two edges back is the one the pipeline saw
	initial begin
		logic [2:0] ack_hist;
		mem_req_t exp;
		ack_hist = '0;
		forever begin
			@(posedge CLK);
			ack_hist = {ack_hist[1:0], 1'($urandom_range(0, 99) < ack_pct)};
			next_REQ_ack <= ack_hist[0];
			@(negedge CLK);
			if (last_REQ_valid && ack_hist[2]) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					$display("%s: request came out with no op in flight", test_name);
					errors++;
				end
				if (exp_q.size() != 0) begin
					exp = exp_q.pop_front();
					assert (last_REQ == exp) else begin
						$display("Fail %s: expected %h actual %h", test_name, exp, last_REQ);
						errors++;
					end
				end
			end
		end
	end

	// ----------------------------------------------------------
	// reference model and op generation

	function automatic mem_req_t expect_req(issue_op_t op, logic [31:0] a, logic [31:0] b);
		mem_req_t r;
		logic [31:0] addr;
		logic [3:0] mask;
		bit mis;
		r = '0;
		r.is_store = op.is_store;
		r.is_amo = op.is_amo;
		r.is_fence = op.is_fence;
		r.op = op.op;
		r.cq_index = op.cq_index;
		addr = a + {{20{op.imm12[11]}}, op.imm12};
		case (op.op[1:0])
			2'd0: mask = 4'h1;
			2'd1: mask = 4'h3;
			default: mask = 4'hf;
		endcase
		mis = (op.op[1:0] == 2'd1 && addr[0]) || (op.op[1:0] == 2'd2 && addr[1:0] != 2'd0);
		r.write_data = b << (8 * addr[1:0]);
		if (!op.is_fence) begin
			r.misaligned = mis;
			r.is_mq = mis && op.is_store && !op.is_amo;
			r.misaligned_exception = mis && op.is_amo;
			r.VPN = addr[31:12];
			r.PO_word = addr[11:2];
			r.byte_mask = mask << addr[1:0];
		end
		return r;
	endfunction

	function automatic operand_src_t rand_src(bit mixed);
		operand_src_t s;
		int kind;
		s = '0;
		kind = mixed ? $urandom_range(0, 3) : 1;
		s.is_reg = (kind == 1);
		s.is_bus_forward = (kind == 2);
		s.is_fast_forward = (kind == 3);
		s.bank = $urandom_range(0, `STAMOFU_PRF_BANK_COUNT-1);
		s.fast_forward_pipe = $urandom_range(0, `STAMOFU_FF_PIPE_COUNT-1);
		return s;
	endfunction

	// mode 1 aligned words, 2 byte/half offsets, 3 AMO and fence, 4 mixed sources, 5 all random
	task automatic make_op(input int mode, input int idx, output issue_op_t op,
		output logic [31:0] a, output logic [31:0] b);
		logic [31:0] addr;
		int flavor;
		op = '0;
		op.imm12 = 12'($urandom);
		op.cq_index = $urandom_range(0, `STAMOFU_CQ_ENTRIES-1);
		op.op[3:2] = $urandom_range(0, 3);
		op.op[1:0] = $urandom_range(0, 2);
		op.A_src = rand_src(mode >= 4);
		op.B_src = rand_src(mode >= 4);
		a = $urandom;
		b = $urandom;
		flavor = (mode == 3) ? 1 + idx % 2 : (mode == 5) ? $urandom_range(0, 2) : 0;
		if (mode == 1)
			op.op[1:0] = 2'd2;
		// every offset once as byte, then once as half
		if (mode == 2)
			op.op[1:0] = 2'((idx / 4) % 2);
		// AMOs may carry the store flag too
		op.is_store = (flavor == 0) || (flavor == 1 && $urandom_range(0, 1) == 1);
		op.is_amo = (flavor == 1);
		op.is_fence = (flavor == 2);
		if (mode <= 2) begin
			addr = a + {{20{op.imm12[11]}}, op.imm12};
			a = a - addr[1:0] + ((mode == 2) ? idx % 4 : 0);
		end
		// sourceless operands are zero, shared bank or pipe gives one word
		if (!(op.A_src.is_reg | op.A_src.is_bus_forward | op.A_src.is_fast_forward))
			a = '0;
		if (!(op.B_src.is_reg | op.B_src.is_bus_forward | op.B_src.is_fast_forward))
			b = '0;
		if (op.A_src.is_bus_forward && op.B_src.is_bus_forward && op.A_src.bank == op.B_src.bank)
			b = a;
		if (op.A_src.is_fast_forward && op.B_src.is_fast_forward
			&& op.A_src.fast_forward_pipe == op.B_src.fast_forward_pipe)
			b = a;
	endtask

	// ----------------------------------------------------------
	// issue and operand drivers

	// acceptance shows on last_issue_ready two edges after the op goes out
	task automatic issue_one(input issue_op_t op, input logic [31:0] a, input logic [31:0] b,
		output bit ok);
		logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] bus;
		int tries;
		ok = 0;
		tries = 0;
		while (!ok && tries < 200) begin
			@(posedge CLK);
			next_issue_valid <= 1'b1;
			next_issue <= op;
			@(posedge CLK);
			next_issue_valid <= 1'b0;
			for (int i = 0; i < `STAMOFU_PRF_BANK_COUNT; i++)
				bus[i] = $urandom;
			if (op.A_src.is_bus_forward)
				bus[op.A_src.bank] = a;
			if (op.B_src.is_bus_forward)
				bus[op.B_src.bank] = b;
			next_bus_forward_data_by_bank <= bus;
			@(posedge CLK);
			@(negedge CLK);
			ok = last_issue_ready;
			tries++;
		end
	endtask

	task automatic pulse_reg(input bit is_b, input logic [31:0] d);
		repeat ($urandom_range(0, 3)) @(posedge CLK);
		@(posedge CLK);
		if (is_b)
			next_B_reg_resp <= '{1'b1, d};
		else
			next_A_reg_resp <= '{1'b1, d};
		@(posedge CLK);
		next_A_reg_resp <= '{1'b0, 32'($urandom)};
		next_B_reg_resp <= '{1'b0, 32'($urandom)};
	endtask

	task automatic pulse_ff(input int pipe, input logic [31:0] d);
		logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] data;
		logic [`STAMOFU_FF_PIPE_COUNT-1:0] v;
		repeat ($urandom_range(0, 3)) @(posedge CLK);
		for (int i = 0; i < `STAMOFU_FF_PIPE_COUNT; i++)
			data[i] = $urandom;
		data[pipe] = d;
		v = '0;
		v[pipe] = 1'b1;
		@(posedge CLK);
		next_fast_forward_valid_by_pipe <= v;
		next_fast_forward_data_by_pipe <= data;
		@(posedge CLK);
		next_fast_forward_valid_by_pipe <= '0;
	endtask

	task automatic deliver(input issue_op_t op, input logic [31:0] a, input logic [31:0] b);
		if (op.A_src.is_reg)
			pulse_reg(1'b0, a);
		else if (op.A_src.is_fast_forward)
			pulse_ff(op.A_src.fast_forward_pipe, a);
		if (op.B_src.is_reg)
			pulse_reg(1'b1, b);
		else if (op.B_src.is_fast_forward && !(op.A_src.is_fast_forward
			&& op.A_src.fast_forward_pipe == op.B_src.fast_forward_pipe))
			pulse_ff(op.B_src.fast_forward_pipe, b);
	endtask

	task automatic run_ops(input string name, input int mode, input int count);
		issue_op_t op;
		logic [31:0] a;
		logic [31:0] b;
		bit ok;
		int err0;
		int n;
		test_name = name;
		err0 = errors;
		for (int i = 0; i < count && !hung; i++) begin
			make_op(mode, i, op, a, b);
			issue_one(op, a, b, ok);
			if (!ok) begin
				$display("%s: op %0d was never accepted", name, i);
				errors++;
				hung = 1;
			end else begin
				exp_q.push_back(expect_req(op, a, b));
				deliver(op, a, b);
			end
		end
		n = 0;
		while (!hung && exp_q.size() != 0 && n < 400) begin
			@(negedge CLK);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%s: %0d requests never came out", name, exp_q.size());
			errors++;
			hung = 1;
		end
		// idle tail catches duplicated requests
		for (int j = 0; j < 8 && !hung; j++)
			@(negedge CLK);
		tests++;
		$display("test %-16s %4d ops  %0d errors", name, count, errors - err0);
	endtask

	// ----------------------------------------------------------
	// test sequence

	initial begin
		int n;
		void'($urandom(32'heeb8_44c3));
		nRST = 1'b0;
		next_issue_valid = 1'b0;
		next_issue = '0;
		next_A_reg_resp = '0;
		next_B_reg_resp = '0;
		next_bus_forward_data_by_bank = '0;
		next_fast_forward_valid_by_pipe = '0;
		next_fast_forward_data_by_pipe = '0;
		next_REQ_ack = 1'b0;
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;

		n = 0;
		while (!last_issue_ready && n < 20) begin
			@(negedge CLK);
			n++;
		end
		assert (last_issue_ready) else begin
			$display("reset: issue ready did not rise after reset");
			errors++;
		end
		// no op issued yet, so no request may show
		for (int j = 0; j < 10; j++) begin
			@(negedge CLK);
			assert (!last_REQ_valid) else begin
				$display("reset: request came out before any op was issued");
				errors++;
			end
		end
		tests++;
		$display("test %-16s %4d ops  %0d errors", "reset", 0, errors);

		run_ops("aligned_word", 1, 20);
		run_ops("byte_half", 2, 32);
		run_ops("amo_fence", 3, 24);
		run_ops("mixed_sources", 4, 40);
		ack_pct = 50;
		run_ops("backpressure", 5, 300);

		$display("%0d tests, %0d requests checked, %0d errors", tests, checks, errors);
		if (errors == 0 && !hung)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- src/core_types_pkg.sv
`include "stamofu_cfg.svh"

package core_types_pkg;

	// ----------------------------------------------------------
	// operand source, one per operand of an issued op

	// at most one of the three flags is set
	// none set means the operand is zero
	typedef struct packed {
		logic is_reg;
		logic is_bus_forward;
		logic is_fast_forward;
		logic [`STAMOFU_LOG_FF_PIPE_COUNT-1:0] fast_forward_pipe;
		logic [`STAMOFU_LOG_PRF_BANK_COUNT-1:0] bank;
	} operand_src_t;

	// ----------------------------------------------------------
	// op as it leaves the issue queue

	typedef struct packed {
		logic is_store;
		logic is_amo;
		logic is_fence;
		// bits 1..0 carry the access size
		logic [3:0] op;
		logic [11:0] imm12;
		// A is the base address, B the store data
		operand_src_t A_src;
		operand_src_t B_src;
		logic [`STAMOFU_LOG_CQ_ENTRIES-1:0] cq_index;
	} issue_op_t;

	// ----------------------------------------------------------
	// register-file read return

	typedef struct packed {
		logic valid;
		logic [31:0] data;
	} reg_resp_t;

endpackage

//--- src/mem_req_pkg.sv
`include "stamofu_cfg.svh"

package mem_req_pkg;

	// access size, encoded in op bits 1..0
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} access_size_e;

	// request held in the REQ stage
	typedef struct packed {
		logic is_store;
		logic is_amo;
		logic is_fence;
		logic [3:0] op;
		// misaligned store, steered to the misaligned queue
		logic is_mq;
		logic misaligned;
		// misaligned AMO, raises an exception instead
		logic misaligned_exception;
		logic [`STAMOFU_VPN_WIDTH-1:0] VPN;
		logic [`STAMOFU_PO_WIDTH-3:0] PO_word;
		logic [3:0] byte_mask;
		// already shifted into byte lanes of the word
		logic [31:0] write_data;
		logic [`STAMOFU_LOG_CQ_ENTRIES-1:0] cq_index;
	} mem_req_t;

endpackage

//--- src/operand_collector.sv
`timescale 1ns/100ps

`include "stamofu_cfg.svh"

module operand_collector (
	input logic CLK,
	input logic nRST,

	// op entry from issue
	input logic load,
	input core_types_pkg::issue_op_t issue,

	// handoff to address calc
	input logic advance,

	// operand returns
	input core_types_pkg::reg_resp_t A_reg_resp,
	input core_types_pkg::reg_resp_t B_reg_resp,
	input logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0] fast_forward_valid_by_pipe,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe,

	// held op
	output logic op_valid,
	output logic op_ready,
	output core_types_pkg::issue_op_t op,
	output logic [31:0] A_data,
	output logic [31:0] B_data
);
	import core_types_pkg::*;

	logic valid_q;
	// high in the cycle after load, the bus-forward slot
	logic first_cycle;
	issue_op_t op_q;

	// index 0 is operand A, index 1 is operand B
	operand_src_t [1:0] src;
	reg_resp_t [1:0] resp;
	logic [1:0] have;
	logic [1:0][31:0] data;

	assign src[0] = op_q.A_src;
	assign src[1] = op_q.B_src;
	assign resp[0] = A_reg_resp;
	assign resp[1] = B_reg_resp;

	// ----------------------------------------------------------
	// op slot

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
			first_cycle <= 1'b0;
		end else begin
			if (load)
				valid_q <= 1'b1;
			else if (advance)
				valid_q <= 1'b0;
			first_cycle <= load;
		end
	end

	always_ff @(posedge CLK) begin
		if (load)
			op_q <= issue;
	end

	// ----------------------------------------------------------
	// per-operand capture

	for (genvar i = 0; i < 2; i++) begin : g_operand
		logic hit;
		logic [31:0] hit_data;

		// reg return wins if a source were ever ambiguous
		always_comb begin
			hit = 1'b0;
			hit_data = resp[i].data;
			if (src[i].is_reg) begin
				hit = resp[i].valid;
			end else if (src[i].is_bus_forward) begin
				hit = first_cycle;
				hit_data = bus_forward_data_by_bank[src[i].bank];
			end else if (src[i].is_fast_forward) begin
				hit = fast_forward_valid_by_pipe[src[i].fast_forward_pipe];
				hit_data = fast_forward_data_by_pipe[src[i].fast_forward_pipe];
			end
		end

		always_ff @(posedge CLK, negedge nRST) begin
			if (!nRST)
				have[i] <= 1'b0;
			else if (load)
				// no source at all: zero operand, ready at once
				have[i] <= ~(issue.A_src.is_reg & (i == 0) | issue.B_src.is_reg & (i == 1)
					| (i == 0 ? issue.A_src.is_bus_forward | issue.A_src.is_fast_forward
					: issue.B_src.is_bus_forward | issue.B_src.is_fast_forward));
			else if (valid_q & ~have[i] & hit)
				have[i] <= 1'b1;
		end

		always_ff @(posedge CLK) begin
			if (load)
				data[i] <= '0;
			else if (valid_q & ~have[i] & hit)
				data[i] <= hit_data;
		end
	end

	assign op_valid = valid_q;
	assign op_ready = valid_q & (&have);
	assign op = op_q;
	assign A_data = data[0];
	assign B_data = data[1];

endmodule

//--- src/stamofu_addr_pipeline.sv
`timescale 1ns/100ps

`include "stamofu_cfg.svh"

module stamofu_addr_pipeline (
	input logic CLK,
	input logic nRST,

	// issue queue side
	input logic issue_valid,
	input core_types_pkg::issue_op_t issue,
	output logic issue_ready,

	// operand returns
	input core_types_pkg::reg_resp_t A_reg_resp,
	input core_types_pkg::reg_resp_t B_reg_resp,
	input logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0] fast_forward_valid_by_pipe,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe,

	// REQ stage
	output logic REQ_valid,
	output mem_req_pkg::mem_req_t REQ,
	input logic REQ_ack
);
	import core_types_pkg::*;
	import mem_req_pkg::*;

	logic stall;
	logic advance;
	logic load;

	logic oc_valid;
	logic oc_ready;
	issue_op_t oc_op;
	logic [31:0] oc_A_data;
	logic [31:0] oc_B_data;
	mem_req_t calc_req;

	// ----------------------------------------------------------
	// stall control

	// REQ held until ack
	assign stall = REQ_valid & ~REQ_ack;
	assign advance = oc_ready & ~stall;
	// empty collector, or one handing off this cycle
	assign issue_ready = ~oc_valid | advance;
	assign load = issue_valid & issue_ready;

	operand_collector collector (
		.CLK(CLK),
		.nRST(nRST),
		.load(load),
		.issue(issue),
		.advance(advance),
		.A_reg_resp(A_reg_resp),
		.B_reg_resp(B_reg_resp),
		.bus_forward_data_by_bank(bus_forward_data_by_bank),
		.fast_forward_valid_by_pipe(fast_forward_valid_by_pipe),
		.fast_forward_data_by_pipe(fast_forward_data_by_pipe),
		.op_valid(oc_valid),
		.op_ready(oc_ready),
		.op(oc_op),
		.A_data(oc_A_data),
		.B_data(oc_B_data)
	);

	store_addr_calc calc (
		.op(oc_op),
		.A_data(oc_A_data),
		.B_data(oc_B_data),
		.req(calc_req)
	);

	// ----------------------------------------------------------
	// REQ stage

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			REQ_valid <= 1'b0;
		else if (advance)
			REQ_valid <= 1'b1;
		else if (REQ_ack)
			REQ_valid <= 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (advance)
			REQ <= calc_req;
	end

endmodule

//--- src/stamofu_addr_top.sv
`timescale 1ns/100ps

`include "stamofu_cfg.svh"

module stamofu_addr_top (
	input logic CLK,
	input logic nRST,

	input logic next_issue_valid,
	input core_types_pkg::issue_op_t next_issue,
	input core_types_pkg::reg_resp_t next_A_reg_resp,
	input core_types_pkg::reg_resp_t next_B_reg_resp,
	input logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] next_bus_forward_data_by_bank,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0] next_fast_forward_valid_by_pipe,
	input logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] next_fast_forward_data_by_pipe,
	input logic next_REQ_ack,

	output logic last_issue_ready,
	output logic last_REQ_valid,
	output mem_req_pkg::mem_req_t last_REQ
);
	import core_types_pkg::*;
	import mem_req_pkg::*;

	// pipeline side of the boundary registers
	logic issue_valid;
	issue_op_t issue;
	logic issue_ready;
	reg_resp_t A_reg_resp;
	reg_resp_t B_reg_resp;
	logic [`STAMOFU_PRF_BANK_COUNT-1:0][31:0] bus_forward_data_by_bank;
	logic [`STAMOFU_FF_PIPE_COUNT-1:0] fast_forward_valid_by_pipe;
	logic [`STAMOFU_FF_PIPE_COUNT-1:0][31:0] fast_forward_data_by_pipe;
	logic REQ_valid;
	mem_req_t REQ;
	logic REQ_ack;

	stamofu_addr_pipeline pipeline (.*);

	// ----------------------------------------------------------
	// one register stage on every input and output

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
			issue <= '0;
			A_reg_resp <= '0;
			B_reg_resp <= '0;
			bus_forward_data_by_bank <= '0;
			fast_forward_valid_by_pipe <= '0;
			fast_forward_data_by_pipe <= '0;
			REQ_ack <= 1'b0;
			last_issue_ready <= 1'b0;
			last_REQ_valid <= 1'b0;
			last_REQ <= '0;
		end else begin
			issue_valid <= next_issue_valid;
			issue <= next_issue;
			A_reg_resp <= next_A_reg_resp;
			B_reg_resp <= next_B_reg_resp;
			bus_forward_data_by_bank <= next_bus_forward_data_by_bank;
			fast_forward_valid_by_pipe <= next_fast_forward_valid_by_pipe;
			fast_forward_data_by_pipe <= next_fast_forward_data_by_pipe;
			REQ_ack <= next_REQ_ack;
			last_issue_ready <= issue_ready;
			last_REQ_valid <= REQ_valid;
			last_REQ <= REQ;
		end
	end

endmodule

//--- src/stamofu_cfg.svh
`ifndef STAMOFU_CFG_SVH
`define STAMOFU_CFG_SVH

// register-file banks seen on the forwarding bus
`define STAMOFU_PRF_BANK_COUNT 4
`define STAMOFU_LOG_PRF_BANK_COUNT $clog2(`STAMOFU_PRF_BANK_COUNT)

// fast-forward pipes from the execution units
`define STAMOFU_FF_PIPE_COUNT 4
`define STAMOFU_LOG_FF_PIPE_COUNT $clog2(`STAMOFU_FF_PIPE_COUNT)

// completion-queue depth, only the index travels with an op
`define STAMOFU_CQ_ENTRIES 16
`define STAMOFU_LOG_CQ_ENTRIES $clog2(`STAMOFU_CQ_ENTRIES)

// virtual address split, 4 KiB pages
`define STAMOFU_VPN_WIDTH 20
`define STAMOFU_PO_WIDTH 12

`endif

//--- src/store_addr_calc.sv
`timescale 1ns/100ps

`include "stamofu_cfg.svh"

module store_addr_calc (
	input core_types_pkg::issue_op_t op,
	input logic [31:0] A_data,
	input logic [31:0] B_data,
	output mem_req_pkg::mem_req_t req
);
	import mem_req_pkg::*;

	logic [31:0] addr;
	access_size_e size;
	logic [3:0] size_mask;
	logic misaligned;

	// base plus sign-extended immediate
	assign addr = A_data + {{20{op.imm12[11]}}, op.imm12};
	assign size = access_size_e'(op.op[1:0]);

	// ----------------------------------------------------------
	// size decode and alignment

	// unused encoding 2'b11 behaves as a word
	always_comb begin
		case (size)
			SIZE_BYTE: begin
				size_mask = 4'b0001;
				misaligned = 1'b0;
			end
			SIZE_HALF: begin
				size_mask = 4'b0011;
				misaligned = addr[0];
			end
			default: begin
				size_mask = 4'b1111;
				misaligned = |addr[1:0];
			end
		endcase
	end

	// ----------------------------------------------------------
	// request build

	always_comb begin
		req = '0;
		req.is_store = op.is_store;
		req.is_amo = op.is_amo;
		req.is_fence = op.is_fence;
		req.op = op.op;
		req.cq_index = op.cq_index;
		// store data lands in its byte lanes
		req.write_data = B_data << {addr[1:0], 3'b000};
		// fences carry no address, mask or alignment info
		if (!op.is_fence) begin
			req.misaligned = misaligned;
			req.is_mq = misaligned & op.is_store & ~op.is_amo;
			req.misaligned_exception = misaligned & op.is_amo;
			req.VPN = addr[31:`STAMOFU_PO_WIDTH];
			req.PO_word = addr[`STAMOFU_PO_WIDTH-1:2];
			req.byte_mask = size_mask << addr[1:0];
		end
	end

endmodule
